// ==== Bender.yml ====
package:
  name: rob

sources:
  - hw/cpu_cfg_pkg.sv
  - hw/rob_pkg.sv
  - hw/rob_tag_cam.sv
  - hw/rob.sv
  - hw/rob_top.sv
  - target: test
    files:
      - testbench/rob_props.sv
      - testbench/rob_tb.sv

// ==== files.f ====
hw/cpu_cfg_pkg.sv
hw/rob_pkg.sv
hw/rob_tag_cam.sv
hw/rob.sv
hw/rob_top.sv
testbench/rob_props.sv
testbench/rob_tb.sv

// ==== hw/cpu_cfg_pkg.sv ====
`default_nettype none

package cpu_cfg_pkg;

	// machine width
	// instructions dispatched per cycle
	// and retired per cycle, same number both ways
	localparam int unsigned ss_width = 2;

	// reorder buffer sizing
	// eight rows in the circular table
	localparam int unsigned rob_depth = 8;

	// row index, wraps at rob_depth
	localparam int unsigned rob_idx_bits = 3;

	// occupancy count, one bit wider than the index
	// so a completely full table still fits
	localparam int unsigned rob_cnt_bits = 4;

	// register files
	// 64 physical registers behind the renamer
	localparam int unsigned phys_tag_bits = 6;

	// 32 architectural registers
	localparam int unsigned arch_reg_bits = 5;

	// store queue
	// index carried by stores for their completion match
	localparam int unsigned sq_idx_bits = 3;

	// program counters and branch targets
	localparam int unsigned addr_bits = 32;

endpackage

`default_nettype wire

// ==== hw/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob (
	input  logic                                                  clock,
	input  logic                                                  rst_n,
	// dispatch, lane 0 oldest
	input  rob_pkg::rob_dispatch_t [cpu_cfg_pkg::ss_width-1:0]    disp,
	// completions
	input  rob_pkg::rob_cdb_t      [cpu_cfg_pkg::ss_width-1:0]    cdb,
	input  rob_pkg::rob_branch_res_t                              br_res,
	input  rob_pkg::rob_sq_done_t                                 sq_done,
	// mispredict recovery
	input  logic                                                  flush,
	// commit side
	output rob_pkg::rob_retire_t   [cpu_cfg_pkg::ss_width-1:0]    retire,
	output logic                   [cpu_cfg_pkg::rob_cnt_bits-1:0] free_rows,
	output logic                                                  full
);

	// stored table and its next value
	rob_pkg::rob_entry_t entries_q [cpu_cfg_pkg::rob_depth];
	rob_pkg::rob_entry_t entries_d [cpu_cfg_pkg::rob_depth];
	// table with this cycle's completions folded in
	rob_pkg::rob_entry_t merged [cpu_cfg_pkg::rob_depth];

	// head is the oldest row, tail the next free one
	logic [cpu_cfg_pkg::rob_idx_bits-1:0] head_q;
	logic [cpu_cfg_pkg::rob_idx_bits-1:0] head_d;
	logic [cpu_cfg_pkg::rob_idx_bits-1:0] tail_q;
	logic [cpu_cfg_pkg::rob_idx_bits-1:0] tail_d;
	// rows in use
	logic [cpu_cfg_pkg::rob_cnt_bits-1:0] count_q;
	logic [cpu_cfg_pkg::rob_cnt_bits-1:0] count_d;

	// cam interface
	rob_pkg::phys_tag_t [cpu_cfg_pkg::rob_depth-1:0] entry_tags;
	logic [cpu_cfg_pkg::rob_depth-1:0] cam_hit;

	// completion sources per row
	logic [cpu_cfg_pkg::rob_depth-1:0] cdb_match;
	logic [cpu_cfg_pkg::rob_depth-1:0] sq_match;
	logic [cpu_cfg_pkg::rob_depth-1:0] br_match;
	logic [cpu_cfg_pkg::rob_depth-1:0] done_now;
	logic [cpu_cfg_pkg::rob_depth-1:0] busy_vec;

	// lane bookkeeping
	logic [cpu_cfg_pkg::rob_idx_bits-1:0] ret_idx  [cpu_cfg_pkg::ss_width];
	logic [cpu_cfg_pkg::rob_idx_bits-1:0] disp_idx [cpu_cfg_pkg::ss_width];
	logic [cpu_cfg_pkg::ss_width-1:0]     ret_ok;
	logic [cpu_cfg_pkg::ss_width-1:0]     disp_ok;
	logic [cpu_cfg_pkg::rob_cnt_bits-1:0] n_ret;
	logic [cpu_cfg_pkg::rob_cnt_bits-1:0] n_disp;
	logic [cpu_cfg_pkg::rob_cnt_bits-1:0] avail;

	// tags presented to the cam, one per row
	always_comb begin
		for (int e = 0; e < cpu_cfg_pkg::rob_depth; e++) begin
			entry_tags[e] = entries_q[e].t_new;
			busy_vec[e]   = entries_q[e].busy;
		end
	end

	rob_tag_cam u_cam (
		.entry_tags (entry_tags),
		.cdb        (cdb),
		.hit        (cam_hit)
	);

	// completion merge
	// each kind of row listens to exactly one source
	always_comb begin
		for (int e = 0; e < cpu_cfg_pkg::rob_depth; e++) begin
			// plain results come off the cdb
			cdb_match[e] = cam_hit[e] && !entries_q[e].is_branch && !entries_q[e].is_store;
			// stores finish when the store queue says so
			sq_match[e] = sq_done.valid && entries_q[e].is_store &&
				(sq_done.sq_idx == entries_q[e].sq_idx);
			// branches are matched on their own tag
			br_match[e] = br_res.valid && entries_q[e].is_branch &&
				(br_res.tag == entries_q[e].t_new);
			done_now[e] = entries_q[e].busy &&
				(entries_q[e].done || cdb_match[e] || sq_match[e] || br_match[e]);

			merged[e]      = entries_q[e];
			merged[e].done = done_now[e];
			// branch outcome lands in the same cycle it resolves
			if (br_match[e]) begin
				merged[e].taken  = br_res.taken;
				merged[e].target = br_res.target;
			end
		end
	end

	// consecutive rows from head and from tail
	for (genvar gl = 0; gl < cpu_cfg_pkg::ss_width; gl++) begin : g_lane_idx
		assign ret_idx[gl]  = head_q + cpu_cfg_pkg::rob_idx_bits'(gl);
		assign disp_idx[gl] = tail_q + cpu_cfg_pkg::rob_idx_bits'(gl);
	end

	// retire
	// stops at the first row that is not done
	always_comb begin
		logic chain;
		chain = !flush;
		n_ret = '0;
		for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
			// rows past the youngest are never busy, so no range check
			chain     = chain && done_now[ret_idx[l]];
			ret_ok[l] = chain;
			n_ret     = n_ret + cpu_cfg_pkg::rob_cnt_bits'(ret_ok[l]);

			retire[l].valid    = ret_ok[l];
			retire[l].t_new    = merged[ret_idx[l]].t_new;
			retire[l].t_old    = merged[ret_idx[l]].t_old;
			retire[l].arch_dst = merged[ret_idx[l]].arch_dst;
			retire[l].npc      = merged[ret_idx[l]].npc;
			retire[l].taken    = merged[ret_idx[l]].taken;
			retire[l].target   = merged[ret_idx[l]].target;
			retire[l].halt     = merged[ret_idx[l]].halt;
			retire[l].illegal  = merged[ret_idx[l]].illegal;
		end
	end

	// rows free at the start of this cycle
	// rows retiring now are only reusable next cycle
	assign avail = cpu_cfg_pkg::rob_cnt_bits'(cpu_cfg_pkg::rob_depth) - count_q;

	// dispatch acceptance, in lane order
	always_comb begin
		logic chain;
		chain  = !flush;
		n_disp = '0;
		for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
			// a lane without a free row is dropped
			chain = chain && disp[l].valid && (avail > cpu_cfg_pkg::rob_cnt_bits'(l));
			disp_ok[l] = chain;
			n_disp     = n_disp + cpu_cfg_pkg::rob_cnt_bits'(disp_ok[l]);
		end
	end

	// next table state
	always_comb begin
		entries_d = merged;

		// release retired rows
		for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
			if (ret_ok[l]) begin
				entries_d[ret_idx[l]].busy = 1'b0;
				entries_d[ret_idx[l]].done = 1'b0;
			end
		end

		// fill new rows at tail
		for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
			if (disp_ok[l]) begin
				entries_d[disp_idx[l]].busy      = 1'b1;
				entries_d[disp_idx[l]].done      = 1'b0;
				entries_d[disp_idx[l]].t_new     = disp[l].t_new;
				entries_d[disp_idx[l]].t_old     = disp[l].t_old;
				entries_d[disp_idx[l]].arch_dst  = disp[l].arch_dst;
				entries_d[disp_idx[l]].npc       = disp[l].npc;
				entries_d[disp_idx[l]].is_branch = disp[l].is_branch;
				entries_d[disp_idx[l]].is_store  = disp[l].is_store;
				entries_d[disp_idx[l]].sq_idx    = disp[l].sq_idx;
				entries_d[disp_idx[l]].halt      = disp[l].halt;
				entries_d[disp_idx[l]].illegal   = disp[l].illegal;
				// cleared until the branch resolves
				entries_d[disp_idx[l]].taken     = 1'b0;
				entries_d[disp_idx[l]].target    = '0;
			end
		end

		// pointers wrap on their own width
		head_d  = head_q + cpu_cfg_pkg::rob_idx_bits'(n_ret);
		tail_d  = tail_q + cpu_cfg_pkg::rob_idx_bits'(n_disp);
		count_d = count_q - n_ret + n_disp;

		// mispredict empties the table
		if (flush) begin
			for (int e = 0; e < cpu_cfg_pkg::rob_depth; e++) begin
				entries_d[e].busy = 1'b0;
				entries_d[e].done = 1'b0;
			end
			head_d  = '0;
			tail_d  = '0;
			count_d = '0;
		end
	end

	// free count after this cycle's retire and dispatch
	assign free_rows = cpu_cfg_pkg::rob_cnt_bits'(cpu_cfg_pkg::rob_depth) - count_d;

	// full from the stored rows only
	assign full = &busy_vec;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			// only the row status bits
			for (int e = 0; e < cpu_cfg_pkg::rob_depth; e++) begin
				entries_q[e].busy <= 1'b0;
				entries_q[e].done <= 1'b0;
			end
		end else begin
			head_q    <= head_d;
			tail_q    <= tail_d;
			count_q   <= count_d;
			entries_q <= entries_d;
		end
	end

endmodule

`default_nettype wire

// ==== hw/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

	// one physical register tag
	typedef logic [cpu_cfg_pkg::phys_tag_bits-1:0] phys_tag_t;

	// one dispatch lane from rename
	typedef struct packed {
		logic                                  valid;
		phys_tag_t                             t_new;
		// previous mapping, freed at retire
		phys_tag_t                             t_old;
		logic [cpu_cfg_pkg::arch_reg_bits-1:0] arch_dst;
		logic [cpu_cfg_pkg::addr_bits-1:0]     npc;
		logic                                  is_branch;
		logic                                  is_store;
		logic [cpu_cfg_pkg::sq_idx_bits-1:0]   sq_idx;
		logic                                  halt;
		logic                                  illegal;
	} rob_dispatch_t;

	// result broadcast, one per cdb lane
	typedef struct packed {
		logic      valid;
		phys_tag_t tag;
	} rob_cdb_t;

	// branch outcome, matched on the branch's own t_new
	typedef struct packed {
		logic                              valid;
		phys_tag_t                         tag;
		logic                              taken;
		logic [cpu_cfg_pkg::addr_bits-1:0] target;
	} rob_branch_res_t;

	// store queue completion
	typedef struct packed {
		logic                                valid;
		logic [cpu_cfg_pkg::sq_idx_bits-1:0] sq_idx;
	} rob_sq_done_t;

	// one table row
	typedef struct packed {
		logic                                  busy;
		logic                                  done;
		phys_tag_t                             t_new;
		phys_tag_t                             t_old;
		logic [cpu_cfg_pkg::arch_reg_bits-1:0] arch_dst;
		logic [cpu_cfg_pkg::addr_bits-1:0]     npc;
		logic                                  is_branch;
		logic                                  is_store;
		logic [cpu_cfg_pkg::sq_idx_bits-1:0]   sq_idx;
		logic                                  halt;
		logic                                  illegal;
		// filled in by the branch resolution
		logic                                  taken;
		logic [cpu_cfg_pkg::addr_bits-1:0]     target;
	} rob_entry_t;

	// one retire lane toward the commit side
	typedef struct packed {
		logic                                  valid;
		phys_tag_t                             t_new;
		phys_tag_t                             t_old;
		logic [cpu_cfg_pkg::arch_reg_bits-1:0] arch_dst;
		logic [cpu_cfg_pkg::addr_bits-1:0]     npc;
		logic                                  taken;
		logic [cpu_cfg_pkg::addr_bits-1:0]     target;
		logic                                  halt;
		logic                                  illegal;
	} rob_retire_t;

endpackage

`default_nettype wire

// ==== hw/rob_tag_cam.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tag_cam (
	// destination tag of every row
	input  rob_pkg::phys_tag_t [cpu_cfg_pkg::rob_depth-1:0] entry_tags,
	// this cycle's broadcasts
	input  rob_pkg::rob_cdb_t  [cpu_cfg_pkg::ss_width-1:0]  cdb,
	// one match bit per row
	output logic               [cpu_cfg_pkg::rob_depth-1:0] hit
);

	// per row, per lane compare results
	logic [cpu_cfg_pkg::ss_width-1:0] lane_match [cpu_cfg_pkg::rob_depth];

	// full crossbar of comparators
	// rows x lanes, no priority between lanes
	always_comb begin
		for (int e = 0; e < cpu_cfg_pkg::rob_depth; e++) begin
			for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
				// an idle lane never matches
				lane_match[e][l] = cdb[l].valid && (cdb[l].tag == entry_tags[e]);
			end
		end
	end

	// reduce lanes per row
	// kind of entry is filtered by the caller
	always_comb begin
		for (int e = 0; e < cpu_cfg_pkg::rob_depth; e++) begin
			hit[e] = |lane_match[e];
		end
	end

endmodule

`default_nettype wire

// ==== hw/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_top (
	input  logic                                                  clock,
	input  logic                                                  rst_n,
	// from rename, lane 0 oldest
	input  rob_pkg::rob_dispatch_t [cpu_cfg_pkg::ss_width-1:0]    disp,
	// result broadcasts
	input  rob_pkg::rob_cdb_t      [cpu_cfg_pkg::ss_width-1:0]    cdb,
	// branch unit outcome
	input  rob_pkg::rob_branch_res_t                              br_res,
	// store queue completion
	input  rob_pkg::rob_sq_done_t                                 sq_done,
	// held high for the flush cycle
	input  logic                                                  flush,
	// toward commit and the free list
	output rob_pkg::rob_retire_t   [cpu_cfg_pkg::ss_width-1:0]    retire,
	// dispatch budget for the next cycle
	output logic                   [cpu_cfg_pkg::rob_cnt_bits-1:0] free_rows,
	// every row busy
	output logic                                                  full
);

	// the buffer itself
	// ports pass straight through
	rob core (
		.clock     (clock),
		.rst_n     (rst_n),
		// dispatch side
		.disp      (disp),
		// completion side
		.cdb       (cdb),
		.br_res    (br_res),
		.sq_done   (sq_done),
		// recovery
		.flush     (flush),
		// retire side
		.retire    (retire),
		.free_rows (free_rows),
		.full      (full)
	);

endmodule

`default_nettype wire

// ==== testbench/rob_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_props (
	input logic                                               clock,
	input logic                                               rst_n,
	input logic                                               flush,
	input rob_pkg::rob_retire_t [cpu_cfg_pkg::ss_width-1:0]   retire,
	input logic                 [cpu_cfg_pkg::rob_cnt_bits-1:0] free_rows,
	input logic                                               full
);

	// lanes retiring this cycle
	logic [cpu_cfg_pkg::rob_cnt_bits-1:0] n_ret;
	assign n_ret = cpu_cfg_pkg::rob_cnt_bits'(retire[0].valid) +
		cpu_cfg_pkg::rob_cnt_bits'(retire[1].valid);

	free_rows_bound: assert property (@(posedge clock) disable iff (!rst_n)
		free_rows <= cpu_cfg_pkg::rob_cnt_bits'(cpu_cfg_pkg::rob_depth))
		else $error("free_rows above the table depth");

	// lanes fill in order
	lane_order: assert property (@(posedge clock) disable iff (!rst_n)
		retire[1].valid |-> retire[0].valid)
		else $error("retire lane 1 valid without lane 0");

	flush_quiet: assert property (@(posedge clock) disable iff (!rst_n)
		flush |-> !(retire[0].valid || retire[1].valid))
		else $error("retire valid during flush");

	// a full table takes no dispatch, only retirements free rows
	full_free: assert property (@(posedge clock) disable iff (!rst_n)
		(full && !flush) |-> (free_rows == n_ret))
		else $error("free_rows differs from retired lanes while full");

endmodule

`default_nettype wire

// ==== testbench/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

	// one in-flight instruction as the model sees it
	typedef struct packed {
		rob_pkg::rob_dispatch_t            d;
		logic                              done;
		logic                              taken;
		logic [cpu_cfg_pkg::addr_bits-1:0] target;
	} model_row_t;

	logic clock;
	logic rst_n;
	rob_pkg::rob_dispatch_t [cpu_cfg_pkg::ss_width-1:0]  disp;
	rob_pkg::rob_cdb_t      [cpu_cfg_pkg::ss_width-1:0]  cdb;
	rob_pkg::rob_branch_res_t                            br_res;
	rob_pkg::rob_sq_done_t                               sq_done;
	logic                                                flush;
	rob_pkg::rob_retire_t   [cpu_cfg_pkg::ss_width-1:0]  retire;
	logic                   [cpu_cfg_pkg::rob_cnt_bits-1:0] free_rows;
	logic                                                full;

	// oldest row at index 0
	model_row_t model_q [$];
	int fail_count;
	int test_base;
	int check_count;
	int retired_total;
	int wait_cnt;
	logic [cpu_cfg_pkg::phys_tag_bits-1:0] tag_ctr;
	logic [cpu_cfg_pkg::sq_idx_bits-1:0]   sq_ctr;

	rob_top uut (.clock(clock), .rst_n(rst_n), .disp(disp), .cdb(cdb), .br_res(br_res),
		.sq_done(sq_done), .flush(flush), .retire(retire), .free_rows(free_rows), .full(full));

	bind rob_top rob_props u_props (.clock(clock), .rst_n(rst_n), .flush(flush),
		.retire(retire), .free_rows(free_rows), .full(full));

	always #5 clock = ~clock;

	// payload only matters on a valid lane
	task automatic check_retire(input int lane, input rob_pkg::rob_retire_t got,
			input rob_pkg::rob_retire_t exp);
		check_count++;
		if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
			$display("error retire[%0d] got %h expected %h", lane, got, exp);
			fail_count++;
		end
	endtask

	task automatic check_free(input logic [cpu_cfg_pkg::rob_cnt_bits-1:0] got,
			input logic [cpu_cfg_pkg::rob_cnt_bits-1:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("error free_rows got %h expected %h", got, exp);
			fail_count++;
		end
	endtask

	task automatic check_full(input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			$display("error full got %h expected %h", got, exp);
			fail_count++;
		end
	endtask

	// kind 0 branch, 1 store, anything else a plain result
	function automatic rob_pkg::rob_dispatch_t make_lane(input int kind);
		rob_pkg::rob_dispatch_t d;
		d = '0;
		d.valid = 1'b1;
		// sequential tags, so no two rows in flight share one
		d.t_new = tag_ctr;
		tag_ctr++;
		d.t_old = rob_pkg::phys_tag_t'($urandom);
		d.arch_dst = cpu_cfg_pkg::arch_reg_bits'($urandom);
		d.npc = $urandom;
		d.is_branch = (kind == 0);
		d.is_store = (kind == 1);
		d.sq_idx = sq_ctr;
		sq_ctr = sq_ctr + cpu_cfg_pkg::sq_idx_bits'(d.is_store);
		d.halt = ($urandom_range(15) == 0);
		d.illegal = ($urandom_range(15) == 0);
		return d;
	endfunction

	// completion rules for one busy row under the current inputs
	function automatic logic row_done(input model_row_t r);
		logic hit;
		hit = r.done;
		for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
			if (cdb[l].valid && cdb[l].tag == r.d.t_new && !r.d.is_branch && !r.d.is_store)
				hit = 1'b1;
		end
		if (sq_done.valid && r.d.is_store && sq_done.sq_idx == r.d.sq_idx)
			hit = 1'b1;
		if (br_res.valid && r.d.is_branch && br_res.tag == r.d.t_new)
			hit = 1'b1;
		return hit;
	endfunction

	task automatic idle_inputs();
		disp = '0;
		cdb = '0;
		br_res = '0;
		sq_done = '0;
		flush = 1'b0;
	endtask

	// 0 to 2 lanes, never more than the model has room for
	task automatic random_dispatch();
		int n;
		n = $urandom_range(2);
		if (n > cpu_cfg_pkg::rob_depth - model_q.size())
			n = cpu_cfg_pkg::rob_depth - model_q.size();
		for (int l = 0; l < n; l++)
			disp[l] = make_lane($urandom_range(3));
	endtask

	// pick random rows, complete each through the source of its kind
	task automatic random_completions();
		model_row_t r;
		if (model_q.size() == 0)
			return;
		for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
			r = model_q[$urandom_range(model_q.size() - 1)];
			if (!r.d.is_branch && !r.d.is_store && $urandom_range(1))
				cdb[l] = '{valid: 1'b1, tag: r.d.t_new};
		end
		r = model_q[$urandom_range(model_q.size() - 1)];
		if (r.d.is_store && $urandom_range(1))
			sq_done = '{valid: 1'b1, sq_idx: r.d.sq_idx};
		r = model_q[$urandom_range(model_q.size() - 1)];
		if (r.d.is_branch && $urandom_range(1))
			br_res = '{valid: 1'b1, tag: r.d.t_new, taken: 1'($urandom_range(1)),
				target: $urandom};
	endtask

	// inputs are set at the falling edge, outputs checked 1 ns later
	task automatic run_cycle();
		model_row_t merged [$];
		rob_pkg::rob_retire_t exp;
		logic [cpu_cfg_pkg::ss_width-1:0] take;
		logic chain;
		int n_ret;
		int n_disp;
		int used;
		#1;
		merged = model_q;
		foreach (merged[i]) begin
			merged[i].done = row_done(model_q[i]);
			if (br_res.valid && merged[i].d.is_branch && br_res.tag == merged[i].d.t_new) begin
				merged[i].taken = br_res.taken;
				merged[i].target = br_res.target;
			end
		end
		// oldest first, stop at the first row still waiting
		chain = !flush;
		n_ret = 0;
		for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
			exp = '0;
			chain = chain && (l < merged.size()) && merged[l].done;
			if (chain) begin
				exp = '{valid: 1'b1, t_new: merged[l].d.t_new, t_old: merged[l].d.t_old,
					arch_dst: merged[l].d.arch_dst, npc: merged[l].d.npc,
					taken: merged[l].taken, target: merged[l].target,
					halt: merged[l].d.halt, illegal: merged[l].d.illegal};
				n_ret++;
			end
			check_retire(l, retire[l], exp);
		end
		// rows freed now are only reusable next cycle
		chain = !flush;
		n_disp = 0;
		for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
			chain = chain && disp[l].valid && (cpu_cfg_pkg::rob_depth - model_q.size() > l);
			take[l] = chain;
			n_disp += int'(chain);
		end
		used = flush ? 0 : model_q.size() - n_ret + n_disp;
		check_free(free_rows, cpu_cfg_pkg::rob_cnt_bits'(cpu_cfg_pkg::rob_depth - used));
		check_full(full, model_q.size() == cpu_cfg_pkg::rob_depth);
		retired_total += n_ret;
		@(posedge clock);
		if (flush) begin
			model_q.delete();
		end else begin
			model_q = merged;
			repeat (n_ret) model_q.delete(0);
			for (int l = 0; l < cpu_cfg_pkg::ss_width; l++) begin
				if (take[l])
					model_q.push_back(model_row_t'{d: disp[l], done: 1'b0, taken: 1'b0,
						target: '0});
			end
		end
		@(negedge clock);
	endtask

	// complete random rows until the table is empty
	task automatic drain_table();
		wait_cnt = 0;
		while (model_q.size() > 0 && wait_cnt < 300) begin
			idle_inputs();
			random_completions();
			run_cycle();
			wait_cnt++;
		end
		if (model_q.size() > 0) begin
			$display("timeout: the table did not drain");
			fail_count++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%0s: %0d mismatches", name, fail_count - test_base);
		test_base = fail_count;
	endtask

	initial begin
		void'($urandom(32'h9f1f_20b4));
		clock = 1'b0;
		rst_n = 1'b0;
		fail_count = 0;
		test_base = 0;
		check_count = 0;
		retired_total = 0;
		tag_ctr = '0;
		sq_ctr = '0;
		idle_inputs();
		repeat (16) @(negedge clock);
		rst_n = 1'b1;
		run_cycle();
		end_test("reset state");

		// no completions, so every row stays busy
		wait_cnt = 0;
		while (model_q.size() < cpu_cfg_pkg::rob_depth && wait_cnt < 40) begin
			idle_inputs();
			random_dispatch();
			run_cycle();
			wait_cnt++;
		end
		if (model_q.size() < cpu_cfg_pkg::rob_depth) begin
			$display("timeout: the table did not fill");
			fail_count++;
		end
		idle_inputs();
		run_cycle();
		drain_table();
		end_test("fill to full");

		for (int c = 0; c < 400; c++) begin
			idle_inputs();
			random_completions();
			random_dispatch();
			run_cycle();
		end
		drain_table();
		end_test("random completion order");

		// store ignores a cdb hit on its own tag
		idle_inputs();
		disp[0] = make_lane(1);
		disp[1] = make_lane(2);
		run_cycle();
		idle_inputs();
		cdb[0] = '{valid: 1'b1, tag: model_q[0].d.t_new};
		cdb[1] = '{valid: 1'b1, tag: model_q[1].d.t_new};
		run_cycle();
		idle_inputs();
		sq_done = '{valid: 1'b1, sq_idx: model_q[0].d.sq_idx};
		run_cycle();
		drain_table();
		end_test("store and cdb completion");

		// plain row at head, branch behind it
		idle_inputs();
		disp[0] = make_lane(2);
		disp[1] = make_lane(0);
		run_cycle();
		// plain row ignores br_res, branch ignores the cdb
		idle_inputs();
		br_res = '{valid: 1'b1, tag: model_q[0].d.t_new, taken: 1'b1, target: $urandom};
		cdb[0] = '{valid: 1'b1, tag: model_q[1].d.t_new};
		run_cycle();
		// resolve and retire in the same cycle
		idle_inputs();
		cdb[0] = '{valid: 1'b1, tag: model_q[0].d.t_new};
		br_res = '{valid: 1'b1, tag: model_q[1].d.t_new, taken: 1'b1, target: $urandom};
		run_cycle();
		drain_table();
		end_test("branch resolution");

		for (int c = 0; c < 200; c++) begin
			idle_inputs();
			random_completions();
			random_dispatch();
			flush = ($urandom_range(15) == 0);
			run_cycle();
		end
		drain_table();
		end_test("flush");

		$display("checks %0d, failures %0d, retired %0d", check_count, fail_count, retired_total);
		if (fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
